/* vlog.f */
+incdir+design
+incdir+verification
design/noc_pkg.sv
design/input_slot.sv
design/oldest_first_arbiter.sv
design/onehot_mux.sv
design/output_port.sv
design/noc_switch.sv
verification/noc_switch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the switch testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal -f vlog.f --top-module noc_switch_tb \
    -o sim_noc_switch > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

./obj_dir/sim_noc_switch > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" "$SIM_LOG"; then
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" "$SIM_LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

/* verification/noc_switch_cases.svh */
// one row per test, applied in order by the stimulus loop
// name, inject mask, dest {in3,in2,in1,in0}, hold mask, hold cycles, idle cycles,
// expected deliveries in the row's window {out3,out2,out1,out0}
task automatic define_cases();
    // lone flits, each to a different output
    add_case("single_in0_out1", 4'b0001, 8'b00_00_00_01, 4'b0000, 0, 2, 16'h0010);
    add_case("single_in1_out2", 4'b0010, 8'b00_00_10_00, 4'b0000, 0, 2, 16'h0100);
    add_case("single_in2_out3", 4'b0100, 8'b00_11_00_00, 4'b0000, 0, 2, 16'h1000);
    add_case("single_in3_out0", 4'b1000, 8'b00_00_00_00, 4'b0000, 0, 2, 16'h0001);

    // full permutation, every output busy in the same cycle
    add_case("four_parallel", 4'b1111, 8'b00_01_10_11, 4'b0000, 0, 2, 16'h1111);

    // three equal-age requesters on out2
    add_case("three_to_out2", 4'b0111, 8'b00_10_10_10, 4'b0000, 0, 3, 16'h0300);

    // in2 waits behind a hold, then in0 joins later
    add_case("oldest_first_early", 4'b0100, 8'b00_01_00_00, 4'b0010, 4, 0, 16'h0000);
    add_case("oldest_first_late", 4'b0001, 8'b00_00_00_01, 4'b0000, 0, 4, 16'h0020);

    // long hold on out3 so both waiting ages saturate
    add_case("hold_saturate_in3", 4'b1000, 8'b11_00_00_00, 4'b1000, 24, 2, 16'h0000);
    add_case("hold_saturate_in1", 4'b0011, 8'b00_00_11_00, 4'b0000, 0, 18, 16'h0001);
    add_case("hold_release", 4'b0100, 8'b00_11_00_00, 4'b0000, 0, 4, 16'h3000);

    // second strobe lands on the edge that grants the first flit
    add_case("reload_first", 4'b0001, 8'b00_00_00_10, 4'b0100, 2, 0, 16'h0000);
    add_case("reload_second", 4'b0001, 8'b00_00_00_10, 4'b0000, 0, 2, 16'h0200);
endtask

/* verification/noc_switch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_defs.svh"

module noc_switch_tb
    import noc_pkg::*;
();

    localparam int N          = `NOC_PORTS;
    localparam int CLK_PERIOD = 40;
    localparam int AGE_MAX    = (1 << `NOC_AGE_W) - 1;

    logic      clk;
    logic      rst_i;
    port_oh_t  in_valid_i;
    flit_t     in_flit_i  [N];
    port_idx_t in_dest_i  [N];
    port_oh_t  out_hold_i;
    port_oh_t  in_busy_o;
    port_oh_t  out_valid_o;
    flit_t     out_flit_o [N];
    port_idx_t out_src_o  [N];

    // test table filled by define_cases
    string      case_name     [$];
    port_oh_t   case_inj      [$];
    logic [7:0] case_dest     [$];
    port_oh_t   case_hold     [$];
    int         case_hold_cyc [$];
    int         case_idle     [$];
    logic [15:0] case_exp     [$];

    int    seed = 32'h75ef_ec4e;
    int    err_cnt = 0;
    int    tests_ok = 0;
    int    tests_bad = 0;
    int    budget_cycles = 0;
    int    cyc = 0;
    string cur_name = "reset";
    int    hold_left [N];
    int    row_cnt   [N]; // deliveries seen in the current row

    // reference slot state
    port_oh_t  m_full;
    int        m_age  [N];
    flit_t     m_flit [N];
    port_idx_t m_dest [N];
    logic [63:0] exp_q [N][$]; // {cycle, pad, source, flit}

    noc_switch noc_switch_inst (
        .clk         (clk),
        .rst_i       (rst_i),
        .in_valid_i  (in_valid_i),
        .in_flit_i   (in_flit_i),
        .in_dest_i   (in_dest_i),
        .out_hold_i  (out_hold_i),
        .in_busy_o   (in_busy_o),
        .out_valid_o (out_valid_o),
        .out_flit_o  (out_flit_o),
        .out_src_o   (out_src_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic add_case(input string name, input port_oh_t inj, input logic [7:0] dest,
                            input port_oh_t hold, input int hold_cyc, input int idle,
                            input logic [15:0] exp_cnt);
        case_name.push_back(name);
        case_inj.push_back(inj);
        case_dest.push_back(dest);
        case_hold.push_back(hold);
        case_hold_cyc.push_back(hold_cyc);
        case_idle.push_back(idle);
        case_exp.push_back(exp_cnt);
    endtask

    `include "noc_switch_cases.svh"

    task automatic check_value(input string what, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("mismatch %s %s expected %0h actual %0h", cur_name, what, exp_v, act_v);
            err_cnt++;
        end
    endtask

    task automatic report_fault(input string msg);
        $display("%s: %s", cur_name, msg);
        err_cnt++;
    endtask

    task automatic report_test(input int err_mark);
        if (err_cnt == err_mark) begin
            $display("test %s ok", cur_name);
            tests_ok++;
        end else begin
            $display("test %s failed with %0d errors", cur_name, err_cnt - err_mark);
            tests_bad++;
        end
    endtask

    // one clock edge with hold levels following their countdowns
    task automatic tick();
        @(posedge clk);
        for (int o = 0; o < N; o++) begin
            out_hold_i[o] <= (hold_left[o] != 0);
            if (hold_left[o] != 0)
                hold_left[o]--;
        end
    endtask

    task automatic run_case(input int n);
        logic [7:0] dests;
        int err_mark;
        cur_name = case_name[n];
        err_mark = err_cnt;
        dests = case_dest[n];
        for (int o = 0; o < N; o++) begin
            row_cnt[o] = 0;
            if (case_hold[n][o])
                hold_left[o] = case_hold_cyc[n];
        end
        tick();
        in_valid_i <= case_inj[n];
        for (int i = 0; i < N; i++) begin
            in_flit_i[i] <= flit_t'($random(seed));
            in_dest_i[i] <= dests[2*i +: 2];
        end
        tick();
        in_valid_i <= '0; // one-cycle strobe
        repeat (case_idle[n]) tick();
        @(negedge clk);
        #1;
        for (int o = 0; o < N; o++)
            check_value($sformatf("deliveries on port %0d", o), 32'(case_exp[n][4*o +: 4]),
                        32'(row_cnt[o]));
        report_test(err_mark);
    endtask

    // reference model where the oldest requester wins and a tie goes to the lowest index
    always @(posedge clk) begin : ref_model
        int win;
        port_oh_t clr;
        cyc = cyc + 1;
        if (rst_i) begin
            m_full = '0;
            for (int i = 0; i < N; i++)
                m_age[i] = 0;
        end else begin
            clr = '0;
            for (int o = 0; o < N; o++) begin
                win = -1;
                for (int i = 0; i < N; i++) begin
                    if (m_full[i] && (m_dest[i] == port_idx_t'(o)) &&
                        (win < 0 || m_age[i] > m_age[win]))
                        win = i;
                end
                if (!out_hold_i[o] && win >= 0) begin
                    exp_q[o].push_back({32'(cyc), 14'd0, port_idx_t'(win), m_flit[win]});
                    clr[win] = 1'b1;
                end
            end
            for (int i = 0; i < N; i++) begin
                if (in_valid_i[i] && (!m_full[i] || clr[i])) begin
                    m_full[i] = 1'b1; // reload beats the clear
                    m_age[i]  = 0;
                    m_flit[i] = in_flit_i[i];
                    m_dest[i] = in_dest_i[i];
                end else if (clr[i]) begin
                    m_full[i] = 1'b0;
                end else if (m_full[i] && m_age[i] < AGE_MAX) begin
                    m_age[i]++;
                end
            end
        end
    end

    // outputs sampled mid-cycle
    always @(negedge clk) begin : out_checker
        logic [63:0] e;
        if (!rst_i) begin
            check_value("in_busy_o", 32'(m_full), 32'(in_busy_o));
            for (int o = 0; o < N; o++) begin
                if (out_valid_o[o]) begin
                    row_cnt[o]++;
                    if (exp_q[o].size() == 0) begin
                        report_fault($sformatf("unexpected flit on output %0d", o));
                    end else begin
                        e = exp_q[o].pop_front();
                        check_value($sformatf("source on port %0d", o), 32'(e[17:16]),
                                    32'(out_src_o[o]));
                        check_value($sformatf("flit on port %0d", o), 32'(e[15:0]),
                                    32'(out_flit_o[o]));
                    end
                end else if (exp_q[o].size() != 0) begin
                    e = exp_q[o].pop_front();
                    report_fault($sformatf("output %0d never delivered the flit due in cycle %0d",
                                           o, e[63:32]));
                end
            end
        end
    end

    initial begin : watchdog
        wait (budget_cycles > 0);
        #(budget_cycles * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", budget_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : stimulus
        int err_mark;
        int total;
        rst_i      = 1'b1;
        in_valid_i = '0;
        out_hold_i = '0;
        for (int i = 0; i < N; i++) begin
            in_flit_i[i] = '0;
            in_dest_i[i] = '0;
            hold_left[i] = 0;
            row_cnt[i]   = 0;
        end
        define_cases();
        total = 10 + 40; // reset plus margin
        for (int n = 0; n < case_name.size(); n++)
            total += 2 + case_idle[n];
        budget_cycles = total;

        repeat (10) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        #1;
        err_mark = err_cnt;
        check_value("out_valid_o after reset", 32'd0, 32'(out_valid_o));
        check_value("in_busy_o after reset", 32'd0, 32'(in_busy_o));
        for (int o = 0; o < N; o++) begin
            check_value($sformatf("flit %0d after reset", o), 32'd0, 32'(out_flit_o[o]));
            check_value($sformatf("source %0d after reset", o), 32'd0, 32'(out_src_o[o]));
        end
        report_test(err_mark);

        for (int n = 0; n < case_name.size(); n++)
            run_case(n);

        cur_name = "end of run";
        for (int o = 0; o < N; o++) begin
            if (exp_q[o].size() != 0)
                report_fault($sformatf("output %0d still owes %0d flits", o, exp_q[o].size()));
        end
        $display("summary: %0d tests ok, %0d tests failed, %0d errors",
                 tests_ok, tests_bad, err_cnt);
        if (tests_bad == 0 && err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/noc_switch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_defs.svh"

module noc_switch
    import noc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  port_oh_t  in_valid_i,
    input  flit_t     in_flit_i  [`NOC_PORTS],
    input  port_idx_t in_dest_i  [`NOC_PORTS],
    input  port_oh_t  out_hold_i,
    output port_oh_t  in_busy_o,
    output port_oh_t  out_valid_o,
    output flit_t     out_flit_o [`NOC_PORTS],
    output port_idx_t out_src_o  [`NOC_PORTS]
);

    localparam int N = `NOC_PORTS;

    port_oh_t  slot_full;
    port_oh_t  slot_clear;
    flit_t     slot_flit [N];
    port_idx_t slot_dest [N];
    age_t      slot_age  [N];

    port_oh_t  out_req     [N]; // per output, one bit per input
    port_oh_t  out_grant   [N]; // per output, one bit per input
    port_oh_t  grant_by_in [N]; // transposed, per input one bit per output

    genvar i, o;
    generate
        for (i = 0; i < N; i++) begin : g_slot
            input_slot u_slot (
                .clk     (clk),
                .rst_i   (rst_i),
                .load_i  (in_valid_i[i]),
                .flit_i  (in_flit_i[i]),
                .dest_i  (in_dest_i[i]),
                .clear_i (slot_clear[i]),
                .full_o  (slot_full[i]),
                .flit_o  (slot_flit[i]),
                .dest_o  (slot_dest[i]),
                .age_o   (slot_age[i])
            );

            assign slot_clear[i] = |grant_by_in[i]; // granted by any output
        end

        for (o = 0; o < N; o++) begin : g_out
            for (i = 0; i < N; i++) begin : g_in
                assign out_req[o][i]     = slot_full[i] & (slot_dest[i] == port_idx_t'(o));
                assign grant_by_in[i][o] = out_grant[o][i];
            end

            output_port u_port (
                .clk     (clk),
                .rst_i   (rst_i),
                .req_i   (out_req[o]),
                .age_i   (slot_age),
                .flit_i  (slot_flit),
                .hold_i  (out_hold_i[o]),
                .grant_o (out_grant[o]),
                .valid_o (out_valid_o[o]),
                .flit_o  (out_flit_o[o]),
                .src_o   (out_src_o[o])
            );
        end
    endgenerate

    assign in_busy_o = slot_full; // busy as long as a flit waits

endmodule

`default_nettype wire

/* design/output_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_defs.svh"

module output_port
    import noc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  port_oh_t  req_i,
    input  age_t      age_i  [`NOC_PORTS],
    input  flit_t     flit_i [`NOC_PORTS],
    input  logic      hold_i,
    output port_oh_t  grant_o,
    output logic      valid_o,
    output flit_t     flit_o,
    output port_idx_t src_o
);

    port_oh_t  grant;
    flit_t     sel_flit;
    port_idx_t sel_src;
    port_idx_t idx_tab [`NOC_PORTS]; // constant source numbers

    logic      valid_q;
    flit_t     flit_q;
    port_idx_t src_q;

    genvar k;
    generate
        for (k = 0; k < `NOC_PORTS; k++) begin : g_idx
            assign idx_tab[k] = port_idx_t'(k);
        end
    endgenerate

    oldest_first_arbiter u_arb (
        .req_i    (req_i),
        .age_i    (age_i),
        .enable_i (~hold_i), // back-pressure stops granting
        .grant_o  (grant)
    );

    onehot_mux #(
        .T (flit_t)
    ) u_flit_mux (
        .sel_i  (grant),
        .data_i (flit_i),
        .data_o (sel_flit)
    );

    // grant to binary source number through the same AND-OR structure
    onehot_mux #(
        .T (port_idx_t)
    ) u_src_mux (
        .sel_i  (grant),
        .data_i (idx_tab),
        .data_o (sel_src)
    );

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            flit_q  <= '0;
            src_q   <= '0;
        end else begin
            valid_q <= |grant; // one-cycle pulse per granted flit
            if (|grant) begin
                flit_q <= sel_flit;
                src_q  <= sel_src;
            end
        end
    end

    assign grant_o = grant; // slot clears on the same edge
    assign valid_o = valid_q;
    assign flit_o  = flit_q;
    assign src_o   = src_q;

endmodule

`default_nettype wire

/* design/onehot_mux.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_defs.svh"

module onehot_mux
    import noc_pkg::*;
#(
    parameter type T = flit_t
) (
    input  port_oh_t sel_i,
    input  T         data_i [`NOC_PORTS],
    output T         data_o
);

    localparam int W = $bits(T);

    logic [W-1:0] acc;

    // mask every leg with its select bit, then OR the legs together
    always_comb begin
        acc = '0;
        for (int i = 0; i < `NOC_PORTS; i++) begin
            acc = acc | (W'(data_i[i]) & {W{sel_i[i]}});
        end
    end

    assign data_o = T'(acc); // zero when nothing is selected

endmodule

`default_nettype wire

/* design/oldest_first_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_defs.svh"

module oldest_first_arbiter
    import noc_pkg::*;
(
    input  port_oh_t req_i,
    input  age_t     age_i [`NOC_PORTS],
    input  logic     enable_i,
    output port_oh_t grant_o
);

    localparam int N = `NOC_PORTS;

    // beats[i][j] set when input i is preferred over input j
    port_oh_t beats [N];

    // Every pair is compared in parallel. For i below j a tie goes to i,
    // for i above j the compare is strict so the tie stays with j. A row
    // that is all ones marks the single oldest requester.
    genvar i, j;
    generate
        for (i = 0; i < N; i++) begin : g_row
            for (j = 0; j < N; j++) begin : g_col
                if (i == j) begin : g_self
                    assign beats[i][j] = 1'b1;
                end else if (i < j) begin : g_upper
                    assign beats[i][j] = ~req_i[j]
                                       | (req_i[i] & (age_i[i] >= age_i[j])); // tie to i
                end else begin : g_lower
                    assign beats[i][j] = req_i[i]
                                       & (~req_i[j] | (age_i[i] > age_i[j])); // tie to j
                end
            end

            assign grant_o[i] = enable_i & req_i[i] & (&beats[i]);
        end
    endgenerate

endmodule

`default_nettype wire

/* design/input_slot.sv */
`timescale 1ns/1ps
`default_nettype none

module input_slot
    import noc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  logic      load_i,
    input  flit_t     flit_i,
    input  port_idx_t dest_i,
    input  logic      clear_i,
    output logic      full_o,
    output flit_t     flit_o,
    output port_idx_t dest_o,
    output age_t      age_o
);

    localparam age_t AGE_MAX = '1;

    logic      full_q;
    flit_t     flit_q;
    port_idx_t dest_q;
    age_t      age_q;
    logic      take;

    // a busy slot only accepts when it is leaving this cycle
    assign take = load_i & (~full_q | clear_i);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            full_q <= 1'b0;
            age_q  <= '0;
        end else begin
            if (take) begin
                full_q <= 1'b1; // new flit wins over a clear
                age_q  <= '0;
            end else if (clear_i) begin
                full_q <= 1'b0;
                age_q  <= '0;
            end else if (full_q && (age_q != AGE_MAX)) begin
                age_q <= age_q + 1'b1; // waiting, saturates at max
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            flit_q <= flit_i;
            dest_q <= dest_i;
        end
    end

    assign full_o = full_q;
    assign flit_o = flit_q;
    assign dest_o = dest_q;
    assign age_o  = age_q;

endmodule

`default_nettype wire

/* design/noc_pkg.sv */
`default_nettype none

`include "noc_defs.svh"

package noc_pkg;

    // one flit of payload, destination travels beside it
    typedef logic [`NOC_FLIT_W-1:0] flit_t;

    // binary port number
    typedef logic [$clog2(`NOC_PORTS)-1:0] port_idx_t;

    // one bit per port, used for requests, grants and port masks
    typedef logic [`NOC_PORTS-1:0] port_oh_t;

    // cycles a flit has waited in its slot
    typedef logic [`NOC_AGE_W-1:0] age_t;

endpackage

`default_nettype wire

/* design/noc_defs.svh */
`ifndef NOC_DEFS_SVH
`define NOC_DEFS_SVH

// switch radix, inputs and outputs alike
`define NOC_PORTS 4

// payload bits carried by one flit
`define NOC_FLIT_W 16

// saturating wait counter in each input slot
`define NOC_AGE_W 4

`endif
